/* src.f */
+incdir+dv
verilog/synth_pkg.sv
verilog/uart_cmd_rx.sv
verilog/tone_gen.sv
verilog/i2s_tx.sv
verilog/synth_top.sv
dv/synth_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the synthesizer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module synth_tb -o synth_sim

out=$(./obj_dir/synth_sim)
echo "$out"

if echo "$out" | grep -q "^Test passed$"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed"
exit 1

/* dv/synth_model.svh */
`ifndef SYNTH_MODEL_SVH
`define SYNTH_MODEL_SVH

// Settings as decoded from the command stream
logic [5:0]       m_freq;
synth_pkg::wave_e m_wave;
logic             m_noise;

// Tone state, one step per rising edge
logic [15:0] m_phase;
logic [15:0] m_lfsr;
logic [7:0]  m_sample;

// Serial word framing
logic m_sck;
logic m_ws;
int   m_bit;

logic [15:0] exp_words[$]; // In the order they leave on sd
string       exp_names[$];

function automatic logic [7:0] sine_at(input logic [3:0] idx);
    logic [7:0] v;
    case (idx)
        4'd0:    v = 8'd128;
        4'd1:    v = 8'd176;
        4'd2:    v = 8'd218;
        4'd3:    v = 8'd246;
        4'd4:    v = 8'd255;
        4'd5:    v = 8'd246;
        4'd6:    v = 8'd218;
        4'd7:    v = 8'd176;
        4'd8:    v = 8'd128;
        4'd9:    v = 8'd80;
        4'd10:   v = 8'd38;
        4'd11:   v = 8'd10;
        4'd12:   v = 8'd0;
        4'd13:   v = 8'd10;
        4'd14:   v = 8'd38;
        default: v = 8'd80;
    endcase
    return v;
endfunction

function automatic logic [7:0] shape_of(input logic [15:0] ph, input synth_pkg::wave_e w);
    logic [7:0] v;
    case (w)
        synth_pkg::WAVE_SAW:    v = ph[15:8];
        synth_pkg::WAVE_SQUARE: v = ph[15] ? 8'hFF : 8'h00;
        synth_pkg::WAVE_SINE:   v = sine_at(ph[15:12]);
        default:                v = ph[15] ? (8'hFF - ph[14:7]) : ph[14:7]; // Folded ramp
    endcase
    return v;
endfunction

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic string wave_name(input synth_pkg::wave_e w, input logic noise);
    string s;
    case (w)
        synth_pkg::WAVE_SAW:    s = "saw";
        synth_pkg::WAVE_SQUARE: s = "square";
        synth_pkg::WAVE_SINE:   s = "sine";
        default:                s = "triangle";
    endcase
    if (noise) begin
        s = {s, "_noise"};
    end
    return s;
endfunction

task automatic apply_cmd(input logic [7:0] c);
    if (c == synth_pkg::CMD_NOISE_ON) begin
        m_noise = 1'b1;
    end else if (c == synth_pkg::CMD_NOISE_OFF) begin
        m_noise = 1'b0;
    end else if (c == synth_pkg::CMD_TRIANGLE) begin
        m_wave = synth_pkg::WAVE_TRIANGLE;
    end else if (c == synth_pkg::CMD_SAW) begin
        m_wave = synth_pkg::WAVE_SAW;
    end else if (c == synth_pkg::CMD_SQUARE) begin
        m_wave = synth_pkg::WAVE_SQUARE;
    end else if (c == synth_pkg::CMD_SINE) begin
        m_wave = synth_pkg::WAVE_SINE;
    end else if (c >= "0" && c <= "9") begin
        m_freq = 6'(c - "0");
    end else if (c >= "A" && c <= "Z") begin
        m_freq = 6'(c - "A" + 8'd10); // 'A' is code 10
    end
endtask

task automatic model_reset();
    m_freq   = 6'd0;
    m_wave   = synth_pkg::WAVE_TRIANGLE;
    m_noise  = 1'b0;
    m_phase  = 16'h0000;
    m_lfsr   = synth_pkg::LFSR_SEED;
    m_sample = 8'h00;
    m_sck    = 1'b0;
    m_ws     = 1'b0;
    m_bit    = 0;
    exp_words.delete();
    exp_names.delete();
endtask

task automatic model_clock();
    logic [7:0] next_sample;
    // Word boundary takes the sample held before this edge
    if (m_sck) begin
        if (m_bit == synth_pkg::I2S_BITS - 1) begin
            m_bit = 0;
            m_ws  = ~m_ws;
            exp_words.push_back({m_sample, m_sample});
            exp_names.push_back(wave_name(m_wave, m_noise));
        end else begin
            m_bit++;
        end
    end
    m_sck = ~m_sck;
    next_sample = shape_of(m_phase, m_wave);
    if (m_noise) begin
        next_sample = next_sample ^ m_lfsr[7:0];
    end
    m_phase  = m_phase + (16'(m_freq) << synth_pkg::PHASE_STEP_SHIFT);
    m_lfsr   = lfsr_next(m_lfsr);
    m_sample = next_sample;
endtask

`endif

/* dv/synth_tb.sv */
`timescale 1ns/1ns

module synth_tb;

    localparam int CLK_PERIOD    = 100;
    localparam int DIRECTED_CMDS = 10;
    localparam int RANDOM_CMDS   = 240;
    localparam int WORD_CLOCKS   = 32;
    localparam int WATCHDOG_CLOCKS =
        ((DIRECTED_CMDS + RANDOM_CMDS) * (9 + 20) + 64 * WORD_CLOCKS) * 2;

    logic clk;
    logic rst_n;
    logic rx;
    logic sck;
    logic ws;
    logic sd;

    int errors;
    int checks;
    int words_done;

    logic [7:0] sent_q[$];  // Bytes on the line, oldest first
    logic [7:0] cmd_byte;
    int         cmd_wait;

    // Capture of the serial words
    logic        ws_prev;
    logic        capturing;
    int          cap_bits;
    logic [15:0] cap_word;
    int          since_toggle;
    int          toggles;

    `include "synth_model.svh"

    synth_top u_synth_top (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .sck   (sck),
        .ws    (ws),
        .sd    (sd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected %0h, actual %0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic send_cmd(input logic [7:0] c);
        @(posedge clk);
        sent_q.push_back(c);
        rx <= 1'b0; // Start bit
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            rx <= c[i]; // LSB first
        end
        @(posedge clk);
        rx <= 1'b1;
        repeat (19) @(posedge clk);
    endtask

    function automatic logic [7:0] random_cmd();
        int unsigned kind;
        int unsigned pick;
        logic [7:0]  c;
        kind = $urandom % 10;
        pick = $urandom;
        if (kind < 2) begin
            case (pick % 4)
                0:       c = synth_pkg::CMD_TRIANGLE;
                1:       c = synth_pkg::CMD_SAW;
                2:       c = synth_pkg::CMD_SQUARE;
                default: c = synth_pkg::CMD_SINE;
            endcase
        end else if (kind == 2) begin
            c = (pick % 2 == 0) ? synth_pkg::CMD_NOISE_ON : synth_pkg::CMD_NOISE_OFF;
        end else if (kind < 5) begin
            c = 8'(32'h30 + pick % 10); // Digit
        end else if (kind < 8) begin
            c = 8'(32'h41 + pick % 26); // Upper case letter
        end else if (kind == 8) begin
            c = 8'(32'h61 + pick % 26); // Lower case, ignored
        end else begin
            c = 8'(32'h21 + pick % 15); // Punctuation, ignored
        end
        return c;
    endfunction

    task automatic score_word(input logic [15:0] w);
        logic [15:0] exp_w;
        string       name;
        words_done++;
        if (words_done == 1) begin
            check_value("reset_word", 32'h0, 32'(w));
        end
        if (exp_words.size() == 0) begin
            errors++;
            $display("Error: a word arrived on sd with no word expected by the model at %0t",
                     $time);
        end else begin
            exp_w = exp_words.pop_front();
            name  = exp_names.pop_front();
            check_value(name, 32'(exp_w), 32'(w));
        end
    endtask

    // Model steps with the DUT and takes commands from the driven line
    always @(posedge clk) begin
        if (!rst_n) begin
            model_reset();
            cmd_wait = 0;
        end else begin
            model_clock();
            if (cmd_wait > 0) begin
                cmd_wait--;
                if (cmd_wait == 0) begin
                    apply_cmd(cmd_byte);
                end
            end else if (!rx) begin
                cmd_byte = sent_q.pop_front();
                cmd_wait = 11; // Settings move 12 edges after the start bit
            end
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            check_value("reset_ws", 32'h0, 32'(ws));
            check_value("reset_sd", 32'h0, 32'(sd));
            ws_prev      = 1'b0;
            capturing    = 1'b0;
            cap_bits     = 0;
            since_toggle = 0;
            toggles      = 0;
        end else begin
            check_value("sck_phase", 32'(m_sck), 32'(sck));
            check_value("ws_timing", 32'(m_ws), 32'(ws));
            since_toggle++;
            // New sd bit is out once sck has fallen
            if (capturing && !sck) begin
                cap_word = {cap_word[14:0], sd};
                cap_bits++;
                if (cap_bits == synth_pkg::I2S_BITS) begin
                    capturing = 1'b0;
                    score_word(cap_word);
                end
            end
            if (ws != ws_prev) begin
                if (toggles > 0) begin
                    check_value("word_period", WORD_CLOCKS, since_toggle);
                end
                toggles++;
                since_toggle = 0;
                ws_prev      = ws;
                capturing    = 1'b1;
                cap_bits     = 0;
            end
        end
    end

    initial begin
        string directed;
        int    done_at_end;
        rst_n      = 1'b0;
        rx         = 1'b1;
        errors     = 0;
        checks     = 0;
        words_done = 0;
        cmd_wait   = 0;
        void'($urandom(32'heab9_ba7b));
        directed = "S7TkQ#WNZF"; // Saw, code, unknown bytes, noise on and off
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        wait (words_done >= 1); // First word still carries the reset settings
        for (int i = 0; i < directed.len(); i++) begin
            send_cmd(directed[i]);
        end
        for (int i = 0; i < RANDOM_CMDS; i++) begin
            send_cmd(random_cmd());
        end
        done_at_end = words_done;
        wait (words_done >= done_at_end + 3);
        $display("Checks: %0d, errors: %0d, words: %0d", checks, errors, words_done);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CLOCKS * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clocks", WATCHDOG_CLOCKS);
        $display("Test failed");
        $finish;
    end

endmodule

/* verilog/synth_top.sv */
`timescale 1ns/1ns

module synth_top (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,  // Serial command input
    output logic sck, // I2S bit clock
    output logic ws,  // I2S word select
    output logic sd   // I2S serial data
);

    synth_pkg::freq_code_t freq_code;
    synth_pkg::wave_e      wave;
    logic                  noise_en;
    synth_pkg::sample_t    sample;

    // Held settings from the command byte
    uart_cmd_rx u_cmd_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (rx),
        .freq_code (freq_code),
        .wave      (wave),
        .noise_en  (noise_en)
    );

    tone_gen u_tone_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .freq_code (freq_code),
        .wave      (wave),
        .noise_en  (noise_en),
        .sample    (sample)
    );

    // Picks up the sample at each word boundary
    i2s_tx u_i2s_tx (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (sample),
        .sck    (sck),
        .ws     (ws),
        .sd     (sd)
    );

endmodule

/* verilog/i2s_tx.sv */
`timescale 1ns/1ns

module i2s_tx (
    input  logic               clk,
    input  logic               rst_n,
    input  synth_pkg::sample_t sample,
    output logic               sck,
    output logic               ws,
    output logic               sd
);

    logic [$clog2(synth_pkg::I2S_BITS)-1:0] bit_cnt; // Bit position within the word
    synth_pkg::i2s_word_t                   word;
    logic                                   word_end;

    assign word_end = (bit_cnt == ($bits(bit_cnt))'(synth_pkg::I2S_BITS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck     <= 1'b0;
            ws      <= 1'b0;
            sd      <= 1'b0;
            bit_cnt <= '0;
            word    <= '0;
        end else begin
            sck <= ~sck; // Half the system clock
            // Everything else moves on the falling edge of sck
            if (sck) begin
                if (word_end) begin
                    bit_cnt <= '0;
                    ws      <= ~ws;
                    word    <= {sample, sample}; // Same byte in both halves
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
                sd <= word[synth_pkg::I2S_BITS - 1 - bit_cnt]; // MSB first
            end
        end
    end

endmodule

/* verilog/tone_gen.sv */
`timescale 1ns/1ns

module tone_gen (
    input  logic                  clk,
    input  logic                  rst_n,
    input  synth_pkg::freq_code_t freq_code,
    input  synth_pkg::wave_e      wave,
    input  logic                  noise_en,
    output synth_pkg::sample_t    sample
);

    synth_pkg::phase_t  phase;
    synth_pkg::phase_t  phase_step;
    logic [15:0]        lfsr;
    logic               lfsr_fb;

    logic [$clog2(synth_pkg::SINE_DEPTH)-1:0] sine_idx;

    synth_pkg::sample_t tri_val;
    synth_pkg::sample_t saw_val;
    synth_pkg::sample_t sqr_val;
    synth_pkg::sample_t sine_val;
    synth_pkg::sample_t shape;
    synth_pkg::sample_t shape_out;

    assign phase_step = synth_pkg::phase_t'(freq_code) << synth_pkg::PHASE_STEP_SHIFT;
    assign lfsr_fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // Maximal length taps

    // Shapes from the top phase bits
    assign saw_val  = phase[15:8];
    assign tri_val  = phase[15] ? ~phase[14:7] : phase[14:7]; // Fold on second half
    assign sqr_val  = {8{phase[15]}};
    assign sine_idx = phase[$bits(synth_pkg::phase_t)-1 -: $clog2(synth_pkg::SINE_DEPTH)];

    // One full sine period, offset binary around 128
    always_comb begin
        case (sine_idx)
            4'd0:    sine_val = 8'd128;
            4'd1:    sine_val = 8'd176;
            4'd2:    sine_val = 8'd218;
            4'd3:    sine_val = 8'd246;
            4'd4:    sine_val = 8'd255; // Peak
            4'd5:    sine_val = 8'd246;
            4'd6:    sine_val = 8'd218;
            4'd7:    sine_val = 8'd176;
            4'd8:    sine_val = 8'd128;
            4'd9:    sine_val = 8'd80;
            4'd10:   sine_val = 8'd38;
            4'd11:   sine_val = 8'd10;
            4'd12:   sine_val = 8'd0;   // Trough
            4'd13:   sine_val = 8'd10;
            4'd14:   sine_val = 8'd38;
            default: sine_val = 8'd80;
        endcase
    end

    always_comb begin
        case (wave)
            synth_pkg::WAVE_TRIANGLE: shape = tri_val;
            synth_pkg::WAVE_SAW:      shape = saw_val;
            synth_pkg::WAVE_SQUARE:   shape = sqr_val;
            default:                  shape = sine_val;
        endcase
    end

    assign shape_out = noise_en ? (shape ^ lfsr[7:0]) : shape;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase  <= '0;
            lfsr   <= synth_pkg::LFSR_SEED;
            sample <= '0;
        end else begin
            phase  <= phase + phase_step; // Wraps at 16 bits
            lfsr   <= {lfsr[14:0], lfsr_fb};
            sample <= shape_out;          // Built from pre-edge phase and LFSR
        end
    end

endmodule

/* verilog/uart_cmd_rx.sv */
`timescale 1ns/1ns

module uart_cmd_rx (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rx,
    output synth_pkg::freq_code_t freq_code,
    output synth_pkg::wave_e      wave,
    output logic                  noise_en
);

    synth_pkg::rx_state_e state;

    logic       rx_meta;    // First synchronizer stage
    logic       rx_sync;    // Stable copy of rx
    logic       rx_last;    // Previous rx_sync for edge detection
    logic       start_edge;
    logic [2:0] bit_cnt;
    logic [7:0] rx_byte;    // Assembled LSB first

    logic [7:0] digit_off;
    logic [7:0] letter_off;
    logic       is_digit;
    logic       is_letter;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1; // Line idles high
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    assign start_edge = rx_last && !rx_sync;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= synth_pkg::RX_IDLE;
            bit_cnt <= 3'd0;
        end else begin
            case (state)
                synth_pkg::RX_IDLE: begin
                    if (start_edge) begin
                        state   <= synth_pkg::RX_DATA;
                        bit_cnt <= 3'd0;
                    end
                end
                synth_pkg::RX_DATA: begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        state <= synth_pkg::RX_DECODE; // Eighth bit taken this edge
                    end
                end
                synth_pkg::RX_DECODE: begin
                    state <= synth_pkg::RX_IDLE;
                end
                default: begin
                    state <= synth_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // One data bit per clock, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == synth_pkg::RX_DATA) begin
            rx_byte <= {rx_sync, rx_byte[7:1]};
        end
    end

    // Character classes for the frequency code
    assign is_digit   = (rx_byte >= 8'h30) && (rx_byte <= 8'h39); // '0' to '9'
    assign is_letter  = (rx_byte >= 8'h41) && (rx_byte <= 8'h5A); // 'A' to 'Z'
    assign digit_off  = rx_byte - 8'h30;
    assign letter_off = rx_byte - 8'h37; // 'A' maps to 10

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            freq_code <= '0;
            wave      <= synth_pkg::WAVE_TRIANGLE;
            noise_en  <= 1'b0;
        end else if (state == synth_pkg::RX_DECODE) begin
            case (rx_byte)
                synth_pkg::CMD_NOISE_ON:  noise_en <= 1'b1;
                synth_pkg::CMD_NOISE_OFF: noise_en <= 1'b0;
                synth_pkg::CMD_TRIANGLE:  wave     <= synth_pkg::WAVE_TRIANGLE;
                synth_pkg::CMD_SAW:       wave     <= synth_pkg::WAVE_SAW;
                synth_pkg::CMD_SQUARE:    wave     <= synth_pkg::WAVE_SQUARE;
                synth_pkg::CMD_SINE:      wave     <= synth_pkg::WAVE_SINE;
                default: begin
                    if (is_digit) begin
                        freq_code <= digit_off[5:0];
                    end else if (is_letter) begin
                        freq_code <= letter_off[5:0];
                    end
                    // Anything else leaves the settings alone
                end
            endcase
        end
    end

endmodule

/* verilog/synth_pkg.sv */
package synth_pkg;

    // Datapath widths
    typedef logic [7:0]  sample_t;    // One audio sample
    typedef logic [5:0]  freq_code_t; // Frequency code 0 to 35
    typedef logic [15:0] phase_t;     // Phase accumulator
    typedef logic [15:0] i2s_word_t;  // One serial audio word

    // Waveform selection
    typedef enum logic [1:0] {
        WAVE_TRIANGLE = 2'd0,
        WAVE_SAW      = 2'd1,
        WAVE_SQUARE   = 2'd2,
        WAVE_SINE     = 2'd3
    } wave_e;

    // Command receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE   = 2'd0, // Waiting for a start bit
        RX_DATA   = 2'd1, // Shifting in eight data bits
        RX_DECODE = 2'd2  // Applying the received byte
    } rx_state_e;

    // Command characters
    localparam logic [7:0] CMD_NOISE_ON  = 8'h4E; // 'N'
    localparam logic [7:0] CMD_NOISE_OFF = 8'h46; // 'F'
    localparam logic [7:0] CMD_TRIANGLE  = 8'h54; // 'T'
    localparam logic [7:0] CMD_SAW       = 8'h53; // 'S'
    localparam logic [7:0] CMD_SQUARE    = 8'h51; // 'Q'
    localparam logic [7:0] CMD_SINE      = 8'h57; // 'W'

    // Tone generation
    localparam int PHASE_STEP_SHIFT = 10;               // Code to phase step
    localparam logic [15:0] LFSR_SEED = 16'hACE1;       // Noise LFSR reset value
    localparam int SINE_DEPTH = 16;                     // Sine table entries

    // Serial audio framing
    localparam int I2S_BITS = 16; // Bits per word

endpackage
